/* flist.f */
+incdir+sim
common/scaler_pkg.sv
rtl/serial_divide.sv
scaler_cfggen/vcfg_axis.sv
scaler_cfggen/hcfg_axis.sv
scaler_cfggen/scaler_cfggen.sv
sim/tb_scaler_cfggen.sv

/* Bender.yml */
package:
  name: scaler_cfggen

sources:
  - files:
      - common/scaler_pkg.sv
      - rtl/serial_divide.sv
      - scaler_cfggen/vcfg_axis.sv
      - scaler_cfggen/hcfg_axis.sv
      - scaler_cfggen/scaler_cfggen.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_scaler_cfggen.sv

/* sim/scaler_ref.svh */
`ifndef SCALER_REF_SVH
`define SCALER_REF_SVH

// floored reciprocal, as the serial divider delivers it
function automatic int unsigned ref_quot(input int unsigned size);
  return (1 << scaler_pkg::FRAC_W) / size;
endfunction

function automatic int unsigned ref_raw(input int unsigned size, input int unsigned full,
                                        input int unsigned act);
  longint unsigned x;
  x = ref_quot(size);
  x = x * full * act;
  return int'((x + (64'd1 << (scaler_pkg::FRAC_W - 1))) >> scaler_pkg::FRAC_W);
endfunction

function automatic int unsigned ref_vfull(input bit pal, input bit boxed, input bit intl);
  int unsigned lines;
  lines = (pal && !boxed) ? scaler_pkg::LINES_PAL : scaler_pkg::LINES_NTSC;
  return intl ? 2 * lines : lines;
endfunction

function automatic int unsigned ref_hfull(input bit nvb);
  return nvb ? scaler_pkg::PIXELS_FULL : scaler_pkg::PIXELS_FULL / 2;
endfunction

function automatic int unsigned ref_needed(input int unsigned size, input int unsigned full,
                                           input int unsigned act);
  int unsigned r;
  r = ref_raw(size, full, act);
  return (r < full) ? r : full;
endfunction

// first line or pixel, boxed only matters for the vertical axis
function automatic int unsigned ref_first(input bit pal, input bit boxed, input bit intl,
                                          input int unsigned size, input int unsigned full,
                                          input int unsigned act);
  int unsigned r;
  int unsigned full_pal;
  r        = ref_raw(size, full, act);
  full_pal = intl ? 2 * scaler_pkg::LINES_PAL : scaler_pkg::LINES_PAL;
  if (pal && boxed) begin
    if (r < full) return (full_pal - r) / 2;
    return intl ? scaler_pkg::BOXED_OFS_INTL : scaler_pkg::BOXED_OFS_PROG;
  end
  return (r < full) ? (full - r) / 2 : 0;
endfunction

`endif

/* sim/tb_scaler_cfggen.sv */
`timescale 1ns/100ps

module tb_scaler_cfggen;

  import scaler_pkg::*;

  `include "scaler_ref.svh"

  localparam int RESET_CYCLES = 16;
  localparam int ROW_WAIT     = 40;
  localparam int BUSY_WAIT    = 80;  // two computations back to back
  localparam int MAX_ROWS     = 64;
  localparam int NUM_RANDOM   = 12;

  logic     SYS_CLK;
  logic     rst_n_i;
  logic     palmode_i, palmode_boxed_i, use_interlaced_full_i, nvideblur_i;
  vid_cfg_t video_config_i;
  vout_t    vlines_out_i;
  hout_t    hpixels_out_i;
  vline_t   vpos_1st_rdline_o, vlines_in_needed_o, vlines_in_full_o;
  vout_t    vlines_out_o;
  interp_t  v_interp_factor_o;
  vline_t   hpos_1st_rdpixel_o, hpixels_in_needed_o, hpixels_in_full_o;
  hout_t    hpixels_out_o;
  interp_t  h_interp_factor_o;

  // stimulus table, one entry per row
  bit       t_pal [MAX_ROWS];
  bit       t_boxed [MAX_ROWS];
  bit       t_intl [MAX_ROWS];
  bit       t_nvb [MAX_ROWS];
  vid_cfg_t t_cfg [MAX_ROWS];
  vout_t    t_vlines [MAX_ROWS];
  hout_t    t_hpix [MAX_ROWS];
  bit       t_chained [MAX_ROWS];  // applied 5 cycles after the row before it

  int          n_rows       = 0;
  int          n_chained    = 0;
  int          errors       = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycle_count  = 0;
  int          cycle_limit  = 0;
  logic [31:0] rng_state    = 32'hde510a5b;

  scaler_cfggen uut (
    .SYS_CLK               (SYS_CLK),
    .rst_n_i               (rst_n_i),
    .palmode_i             (palmode_i),
    .palmode_boxed_i       (palmode_boxed_i),
    .use_interlaced_full_i (use_interlaced_full_i),
    .nvideblur_i           (nvideblur_i),
    .video_config_i        (video_config_i),
    .vlines_out_i          (vlines_out_i),
    .hpixels_out_i         (hpixels_out_i),
    .vpos_1st_rdline_o     (vpos_1st_rdline_o),
    .vlines_in_needed_o    (vlines_in_needed_o),
    .vlines_in_full_o      (vlines_in_full_o),
    .vlines_out_o          (vlines_out_o),
    .v_interp_factor_o     (v_interp_factor_o),
    .hpos_1st_rdpixel_o    (hpos_1st_rdpixel_o),
    .hpixels_in_needed_o   (hpixels_in_needed_o),
    .hpixels_in_full_o     (hpixels_in_full_o),
    .hpixels_out_o         (hpixels_out_o),
    .h_interp_factor_o     (h_interp_factor_o)
  );

  initial begin
    SYS_CLK = 1'b0;
    forever #4 SYS_CLK = ~SYS_CLK;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned preset_vactive(input vid_cfg_t cfg);
    case (cfg)
      2'd0:    return 480;
      2'd1:    return 720;
      2'd2:    return 960;
      default: return 1080;
    endcase
  endfunction

  function automatic int unsigned preset_hactive(input vid_cfg_t cfg);
    case (cfg)
      2'd0:    return 640;
      2'd3:    return 1920;
      default: return 1280;
    endcase
  endfunction

  task automatic add_row(input bit pal, input bit boxed, input bit intl, input bit nvb,
                         input int cfg, input int vl, input int hp, input bit chained);
    t_pal[n_rows]     = pal;
    t_boxed[n_rows]   = boxed;
    t_intl[n_rows]    = intl;
    t_nvb[n_rows]     = nvb;
    t_cfg[n_rows]     = vid_cfg_t'(cfg);
    t_vlines[n_rows]  = vout_t'(vl);
    t_hpix[n_rows]    = hout_t'(hp);
    t_chained[n_rows] = chained;
    if (chained) n_chained++;
    n_rows++;
  endtask

  task automatic build_table();
    int vl;
    int hp;
    add_row(0, 0, 0, 0, 0, 480, 640, 0);  // reset input values, nothing changes
    for (int p = 0; p < 2; p++) begin
      for (int l = 0; l < 2; l++) begin
        for (int c = 0; c < 4; c++) begin
          vl = preset_vactive(vid_cfg_t'(c)) + 100 + 60 * p + 30 * l;
          hp = preset_hactive(vid_cfg_t'(c)) + 200 + 40 * c;
          add_row(p, 0, l, c % 2, c, vl, hp, 0);
        end
      end
    end
    add_row(1, 1, 0, 0, 0, 480, 640, 0);    // fixed offset 24
    add_row(1, 1, 0, 0, 3, 1200, 2000, 0);  // centred in the pal frame
    add_row(1, 1, 1, 0, 0, 480, 700, 0);    // fixed offset 48
    add_row(1, 1, 1, 1, 3, 1900, 2200, 0);
    add_row(0, 0, 0, 1, 1, 900, 1000, 0);
    add_row(0, 0, 0, 0, 1, 900, 1000, 0);
    add_row(0, 0, 0, 1, 3, 1200, 2400, 0);
    add_row(0, 0, 0, 0, 3, 1200, 1500, 0);
    add_row(0, 0, 0, 1, 3, 300, 500, 0);    // needed above full on both axes
    add_row(1, 0, 1, 0, 2, 400, 900, 0);
    for (int k = 0; k < NUM_RANDOM; k++) begin
      rng_state = lcg_next(rng_state);
      vl        = 240 + int'((rng_state >> 4) % 1808);
      hp        = rng_state[31:30];
      rng_state = lcg_next(rng_state);
      add_row(rng_state[31], rng_state[30], rng_state[29], rng_state[28], hp, vl,
              320 + int'((rng_state >> 4) % 3774), 0);
    end
    add_row(0, 0, 0, 1, 2, 1000, 1500, 0);
    add_row(0, 0, 0, 1, 2, 1300, 2000, 1);  // size change while busy
    add_row(1, 0, 1, 0, 1, 900, 1400, 0);
    add_row(0, 0, 0, 1, 3, 1100, 2100, 1);  // mode change while busy
  endtask

  task automatic apply_row(input int i);
    palmode_i             <= t_pal[i];
    palmode_boxed_i       <= t_boxed[i];
    use_interlaced_full_i <= t_intl[i];
    nvideblur_i           <= t_nvb[i];
    video_config_i        <= t_cfg[i];
    vlines_out_i          <= t_vlines[i];
    hpixels_out_i         <= t_hpix[i];
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
      end
  endtask

  task automatic check_row(input int i);
    int unsigned vact, hact, vfull, hfull, vsize, hsize;
    int          errs_before;
    errs_before = errors;
    vact  = preset_vactive(t_cfg[i]);
    hact  = preset_hactive(t_cfg[i]);
    vfull = ref_vfull(t_pal[i], t_boxed[i], t_intl[i]);
    hfull = ref_hfull(t_nvb[i]);
    vsize = t_vlines[i];
    hsize = t_hpix[i];
    check_value("vpos_1st_rdline_o", vpos_1st_rdline_o,
                ref_first(t_pal[i], t_boxed[i], t_intl[i], vsize, vfull, vact));
    check_value("vlines_in_needed_o", vlines_in_needed_o, ref_needed(vsize, vfull, vact));
    check_value("vlines_in_full_o", vlines_in_full_o, vfull);
    check_value("vlines_out_o", vlines_out_o, vsize);
    check_value("v_interp_factor_o", v_interp_factor_o, ref_quot(vsize));
    check_value("hpos_1st_rdpixel_o", hpos_1st_rdpixel_o,
                ref_first(1'b0, 1'b0, 1'b0, hsize, hfull, hact));
    check_value("hpixels_in_needed_o", hpixels_in_needed_o, ref_needed(hsize, hfull, hact));
    check_value("hpixels_in_full_o", hpixels_in_full_o, hfull);
    check_value("hpixels_out_o", hpixels_out_o, hsize);
    check_value("h_interp_factor_o", h_interp_factor_o, ref_quot(hsize));
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("test %0d: %s (pal %0d boxed %0d intl %0d nvb %0d cfg %0d lines %0d pixels %0d)",
             i, (errors == errs_before) ? "ok" : "error", t_pal[i], t_boxed[i], t_intl[i],
             t_nvb[i], t_cfg[i], vsize, hsize);
  endtask

  initial begin
    rst_n_i               <= 1'b0;
    palmode_i             <= 1'b0;
    palmode_boxed_i       <= 1'b0;
    use_interlaced_full_i <= 1'b0;
    nvideblur_i           <= 1'b0;
    video_config_i        <= 2'd0;
    vlines_out_i          <= 11'd480;
    hpixels_out_i         <= 12'd640;
    build_table();
    cycle_limit = RESET_CYCLES + n_rows * (ROW_WAIT + 1) + n_chained * BUSY_WAIT + 200;
    repeat (RESET_CYCLES) @(posedge SYS_CLK);
    rst_n_i <= 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge SYS_CLK);
      apply_row(i);
      if ((i + 1 < n_rows) && t_chained[i+1]) begin
        repeat (4) @(posedge SYS_CLK);  // next apply lands 5 cycles later
      end else begin
        repeat (t_chained[i] ? BUSY_WAIT : ROW_WAIT) @(posedge SYS_CLK);
        @(negedge SYS_CLK);
        check_row(i);
      end
    end
    $display("tests run %0d, tests with errors %0d, mismatches %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge SYS_CLK) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

/* scaler_cfggen/scaler_cfggen.sv */
`timescale 1ns/100ps

module scaler_cfggen (
  input  logic                 SYS_CLK,
  input  logic                 rst_n_i,
  input  logic                 palmode_i,
  input  logic                 palmode_boxed_i,
  input  logic                 use_interlaced_full_i,
  input  logic                 nvideblur_i,
  input  scaler_pkg::vid_cfg_t video_config_i,
  input  scaler_pkg::vout_t    vlines_out_i,
  input  scaler_pkg::hout_t    hpixels_out_i,
  output scaler_pkg::vline_t   vpos_1st_rdline_o,
  output scaler_pkg::vline_t   vlines_in_needed_o,
  output scaler_pkg::vline_t   vlines_in_full_o,
  output scaler_pkg::vout_t    vlines_out_o,
  output scaler_pkg::interp_t  v_interp_factor_o,
  output scaler_pkg::vline_t   hpos_1st_rdpixel_o,
  output scaler_pkg::vline_t   hpixels_in_needed_o,
  output scaler_pkg::vline_t   hpixels_in_full_o,
  output scaler_pkg::hout_t    hpixels_out_o,
  output scaler_pkg::interp_t  h_interp_factor_o
);

  import scaler_pkg::*;

  logic  pal_l, boxed_l, intl_l, nvb_l;  // modes, only updated while the axis idles
  logic  trig_v, trig_h;                 // toggle on every accepted mode change
  logic  v_idle, h_idle;
  vout_t vactive_q;
  hout_t hactive_q;
  vout_t vsize_q;
  hout_t hsize_q;

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pal_l   <= 1'b0;
      boxed_l <= 1'b0;
      intl_l  <= 1'b0;
      nvb_l   <= 1'b0;
      trig_v  <= 1'b0;
      trig_h  <= 1'b0;
    end else begin
      if (v_idle && ({palmode_i, palmode_boxed_i, use_interlaced_full_i} !=
                     {pal_l, boxed_l, intl_l})) begin
        pal_l   <= palmode_i;
        boxed_l <= palmode_boxed_i;
        intl_l  <= use_interlaced_full_i;
        trig_v  <= ~trig_v;
      end
      if (h_idle && (nvideblur_i != nvb_l)) begin
        nvb_l  <= nvideblur_i;
        trig_h <= ~trig_h;
      end
    end
  end

  // preset decode and output sizes share one stage with the mode latches
  always_ff @(posedge SYS_CLK) begin
    vactive_q <= VACTIVE_TAB[video_config_i];
    hactive_q <= HACTIVE_TAB[video_config_i];
    vsize_q   <= vlines_out_i;
    hsize_q   <= hpixels_out_i;
  end

  vcfg_axis u_vcfg (
    .SYS_CLK            (SYS_CLK),
    .rst_n_i            (rst_n_i),
    .trig_i             (trig_v),
    .pal_i              (pal_l),
    .boxed_i            (boxed_l),
    .intl_i             (intl_l),
    .vactive_i          (vactive_q),
    .vlines_out_i       (vsize_q),
    .idle_o             (v_idle),
    .vpos_1st_rdline_o  (vpos_1st_rdline_o),
    .vlines_in_needed_o (vlines_in_needed_o),
    .vlines_in_full_o   (vlines_in_full_o),
    .vlines_out_o       (vlines_out_o),
    .v_interp_factor_o  (v_interp_factor_o)
  );

  hcfg_axis u_hcfg (
    .SYS_CLK             (SYS_CLK),
    .rst_n_i             (rst_n_i),
    .trig_i              (trig_h),
    .nvideblur_i         (nvb_l),
    .hactive_i           (hactive_q),
    .hpixels_out_i       (hsize_q),
    .idle_o              (h_idle),
    .hpos_1st_rdpixel_o  (hpos_1st_rdpixel_o),
    .hpixels_in_needed_o (hpixels_in_needed_o),
    .hpixels_in_full_o   (hpixels_in_full_o),
    .hpixels_out_o       (hpixels_out_o),
    .h_interp_factor_o   (h_interp_factor_o)
  );

endmodule

/* scaler_cfggen/hcfg_axis.sv */
`timescale 1ns/100ps

module hcfg_axis (
  input  logic                SYS_CLK,
  input  logic                rst_n_i,
  input  logic                trig_i,
  input  logic                nvideblur_i,
  input  scaler_pkg::hout_t   hactive_i,
  input  scaler_pkg::hout_t   hpixels_out_i,
  output logic                idle_o,
  output scaler_pkg::vline_t  hpos_1st_rdpixel_o,
  output scaler_pkg::vline_t  hpixels_in_needed_o,
  output scaler_pkg::vline_t  hpixels_in_full_o,
  output scaler_pkg::hout_t   hpixels_out_o,
  output scaler_pkg::interp_t h_interp_factor_o
);

  import scaler_pkg::*;

  cfg_state_e state;
  wait_cnt_t  wait_cnt;
  logic       pending;
  logic       trig_q, nvb_q;
  hout_t      act_q, size_q;
  logic       change;

  logic       div_start, div_busy, div_done;
  interp_t    quot;

  vline_t     full;
  logic [INV_W-1:0]          inv_q;
  logic [HPROD_W-1:0]        prod_q;
  logic [HPROD_W-FRAC_W-1:0] resmax_q;
  vline_t     needed_q, full_q, first_q;

  assign idle_o = (state == ST_RDY);
  assign change = pending || (trig_i != trig_q) || (hactive_i != act_q) ||
                  (hpixels_out_i != size_q);
  assign full   = nvb_q ? PIXELS_FULL : PIXELS_FULL >> 1;  // blur halves the pixel count

  always_ff @(posedge SYS_CLK) begin
    inv_q    <= quot * full;
    prod_q   <= inv_q * act_q;
    resmax_q <= prod_q[HPROD_W-1:FRAC_W] + prod_q[FRAC_W-1];
    needed_q <= (resmax_q < full) ? vline_t'(resmax_q) : full;
    full_q   <= full;
    first_q  <= (resmax_q < full) ? (full - vline_t'(resmax_q)) >> 1 : '0;
  end

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state               <= ST_RDY;
      wait_cnt            <= '0;
      pending             <= 1'b1;
      div_start           <= 1'b0;
      trig_q              <= 1'b0;
      nvb_q               <= 1'b0;
      act_q               <= '0;
      size_q              <= '0;
      hpos_1st_rdpixel_o  <= '0;
      hpixels_in_needed_o <= '0;
      hpixels_in_full_o   <= '0;
      hpixels_out_o       <= '0;
      h_interp_factor_o   <= '0;
    end else begin
      div_start <= 1'b0;
      case (state)
        ST_RDY: begin
          if (change && !div_busy) begin
            state     <= ST_DIVWAIT;
            div_start <= 1'b1;
            pending   <= 1'b0;
            trig_q    <= trig_i;
            nvb_q     <= nvideblur_i;
            act_q     <= hactive_i;
            size_q    <= hpixels_out_i;
          end
        end
        ST_DIVWAIT: begin
          if (div_done) begin
            state    <= ST_WAIT;
            wait_cnt <= WAIT_CYCLES;
          end
        end
        ST_WAIT: begin
          if (wait_cnt == '0) begin
            state <= ST_OUT;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: begin  // ST_OUT
          state               <= ST_RDY;
          hpos_1st_rdpixel_o  <= first_q;
          hpixels_in_needed_o <= needed_q;
          hpixels_in_full_o   <= full_q;
          hpixels_out_o       <= size_q;
          h_interp_factor_o   <= quot;
        end
      endcase
    end
  end

  serial_divide u_div (
    .SYS_CLK    (SYS_CLK),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .divisor_i  (size_q),
    .quotient_o (quot),
    .busy_o     (div_busy),
    .done_o     (div_done)
  );

  // divider latency bounds the wait for done
  assert property (@(posedge SYS_CLK) disable iff (!rst_n_i)
    $rose(state == ST_DIVWAIT) |-> ##[1:20] (state != ST_DIVWAIT))
    else $error("horizontal axis stuck waiting for the divider");

endmodule

/* scaler_cfggen/vcfg_axis.sv */
`timescale 1ns/100ps

module vcfg_axis (
  input  logic                SYS_CLK,
  input  logic                rst_n_i,
  input  logic                trig_i,
  input  logic                pal_i,
  input  logic                boxed_i,
  input  logic                intl_i,
  input  scaler_pkg::vout_t   vactive_i,
  input  scaler_pkg::vout_t   vlines_out_i,
  output logic                idle_o,
  output scaler_pkg::vline_t  vpos_1st_rdline_o,
  output scaler_pkg::vline_t  vlines_in_needed_o,
  output scaler_pkg::vline_t  vlines_in_full_o,
  output scaler_pkg::vout_t   vlines_out_o,
  output scaler_pkg::interp_t v_interp_factor_o
);

  import scaler_pkg::*;

  cfg_state_e state;
  wait_cnt_t  wait_cnt;
  logic       pending;  // one run after reset without any input change
  logic       trig_q, pal_q, boxed_q, intl_q;
  vout_t      act_q, size_q;
  logic       change;

  logic       div_start, div_busy, div_done;
  interp_t    quot;

  vline_t     full_ntsc, full_pal, full;
  vline_t     first_normal, first_boxed;
  logic [INV_W-1:0]          inv_q;
  logic [VPROD_W-1:0]        prod_q;
  logic [VPROD_W-FRAC_W-1:0] resmax_q;
  vline_t     needed_q, full_q, first_q;

  assign idle_o = (state == ST_RDY);
  assign change = pending || (trig_i != trig_q) || (vactive_i != act_q) ||
                  (vlines_out_i != size_q);

  assign full_ntsc = intl_q ? vline_t'(2 * LINES_NTSC) : LINES_NTSC;
  assign full_pal  = intl_q ? vline_t'(2 * LINES_PAL) : LINES_PAL;
  assign full      = (pal_q && !boxed_q) ? full_pal : full_ntsc;

  assign first_normal = (resmax_q < full) ? (full - vline_t'(resmax_q)) >> 1 : '0;
  // boxed PAL centres small pictures in the PAL frame, large ones get a fixed offset
  assign first_boxed  = (resmax_q < full_ntsc) ? (full_pal - vline_t'(resmax_q)) >> 1 :
                        (intl_q ? BOXED_OFS_INTL : BOXED_OFS_PROG);

  always_ff @(posedge SYS_CLK) begin
    inv_q    <= quot * full;                                        // stage 1
    prod_q   <= inv_q * act_q;                                      // stage 2
    resmax_q <= prod_q[VPROD_W-1:FRAC_W] + prod_q[FRAC_W-1];        // stage 3, round
    needed_q <= (resmax_q < full) ? vline_t'(resmax_q) : full;      // stage 4, clamp
    full_q   <= full;
    first_q  <= (pal_q && boxed_q) ? first_boxed : first_normal;
  end

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state              <= ST_RDY;
      wait_cnt           <= '0;
      pending            <= 1'b1;
      div_start          <= 1'b0;
      trig_q             <= 1'b0;
      pal_q              <= 1'b0;
      boxed_q            <= 1'b0;
      intl_q             <= 1'b0;
      act_q              <= '0;
      size_q             <= '0;
      vpos_1st_rdline_o  <= '0;
      vlines_in_needed_o <= '0;
      vlines_in_full_o   <= '0;
      vlines_out_o       <= '0;
      v_interp_factor_o  <= '0;
    end else begin
      div_start <= 1'b0;
      case (state)
        ST_RDY: begin
          if (change && !div_busy) begin
            state     <= ST_DIVWAIT;
            div_start <= 1'b1;
            pending   <= 1'b0;
            trig_q    <= trig_i;  // snapshot the latest values
            pal_q     <= pal_i;
            boxed_q   <= boxed_i;
            intl_q    <= intl_i;
            act_q     <= vactive_i;
            size_q    <= vlines_out_i;
          end
        end
        ST_DIVWAIT: begin
          if (div_done) begin
            state    <= ST_WAIT;
            wait_cnt <= WAIT_CYCLES;
          end
        end
        ST_WAIT: begin
          if (wait_cnt == '0) begin
            state <= ST_OUT;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: begin  // ST_OUT, all outputs move together
          state              <= ST_RDY;
          vpos_1st_rdline_o  <= first_q;
          vlines_in_needed_o <= needed_q;
          vlines_in_full_o   <= full_q;
          vlines_out_o       <= size_q;
          v_interp_factor_o  <= quot;
        end
      endcase
    end
  end

  serial_divide u_div (
    .SYS_CLK    (SYS_CLK),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .divisor_i  ({1'b0, size_q}),
    .quotient_o (quot),
    .busy_o     (div_busy),
    .done_o     (div_done)
  );

  assert property (@(posedge SYS_CLK) disable iff (!rst_n_i) div_start |-> !div_busy)
    else $error("vertical divider started while busy");
  assert property (@(posedge SYS_CLK) disable iff (!rst_n_i) div_start |-> (size_q != '0))
    else $error("vertical divider started with a zero divisor");

endmodule

/* rtl/serial_divide.sv */
`timescale 1ns/100ps

module serial_divide (
  input  logic                SYS_CLK,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  scaler_pkg::hout_t   divisor_i,
  output scaler_pkg::interp_t quotient_o,
  output logic                busy_o,
  output logic                done_o
);

  import scaler_pkg::*;

  div_cnt_t               cnt;    // remaining quotient bits
  hout_t                  rem;    // partial remainder, always below the divisor
  interp_t                dvd;    // dividend bits not yet shifted in
  interp_t                quot;
  logic [$bits(hout_t):0] trial;
  logic                   fits;

  assign trial = {rem, dvd[DIVIDEND_W-1]};
  assign fits  = (trial >= {1'b0, divisor_i});

  always_ff @(posedge SYS_CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt    <= '0;
      rem    <= '0;
      dvd    <= '0;
      quot   <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && (cnt == '0)) begin
        cnt <= div_cnt_t'(DIVIDEND_W);
        rem <= '0;
        dvd <= DIVIDEND;
      end else if (cnt != '0) begin
        cnt    <= cnt - 1'b1;
        rem    <= fits ? hout_t'(trial - {1'b0, divisor_i}) : hout_t'(trial);
        dvd    <= dvd << 1;
        quot   <= {quot[DIVIDEND_W-2:0], fits};  // msb first
        done_o <= (cnt == div_cnt_t'(1));        // last bit lands this edge
      end
    end
  end

  assign quotient_o = quot;
  assign busy_o     = (cnt != '0);

  // an accepted start yields one single-cycle done once every quotient bit is in
  assert property (@(posedge SYS_CLK) disable iff (!rst_n_i)
    (start_i && !busy_o) |=> !done_o [*DIVIDEND_W] ##1 done_o ##1 !done_o)
    else $error("divider done pulse missing, late or wider than one cycle");

endmodule

/* common/scaler_pkg.sv */
package scaler_pkg;

  localparam int DIVIDEND_W = 18;
  localparam int FRAC_W     = 17;  // fraction bits dropped by the rounding stage
  localparam int DIV_CNT_W  = 5;

  typedef logic [1:0]            vid_cfg_t;   // video preset code
  typedef logic [9:0]            vline_t;     // console line or pixel count / position
  typedef logic [10:0]           vout_t;      // output line count
  typedef logic [11:0]           hout_t;      // output pixel count
  typedef logic [DIVIDEND_W-1:0] interp_t;    // reciprocal quotient
  typedef logic [2:0]            wait_cnt_t;
  typedef logic [DIV_CNT_W-1:0]  div_cnt_t;

  // product widths of the two multiply stages
  localparam int INV_W   = DIVIDEND_W + $bits(vline_t);
  localparam int VPROD_W = INV_W + $bits(vout_t);
  localparam int HPROD_W = INV_W + $bits(hout_t);

  localparam interp_t DIVIDEND = interp_t'(1) << FRAC_W;  // 2^17

  localparam vline_t LINES_NTSC  = 10'd240;
  localparam vline_t LINES_PAL   = 10'd288;
  localparam vline_t PIXELS_FULL = 10'd640;

  localparam vline_t BOXED_OFS_PROG = 10'd24;
  localparam vline_t BOXED_OFS_INTL = 10'd48;

  // active output size per preset
  localparam vout_t VACTIVE_TAB [4] = '{11'd480, 11'd720, 11'd960, 11'd1080};
  localparam hout_t HACTIVE_TAB [4] = '{12'd640, 12'd1280, 12'd1280, 12'd1920};

  localparam wait_cnt_t WAIT_CYCLES = 3'd4;  // covers the four pipeline stages

  typedef enum logic [1:0] {
    ST_RDY     = 2'b00,
    ST_DIVWAIT = 2'b01,
    ST_WAIT    = 2'b10,
    ST_OUT     = 2'b11
  } cfg_state_e;

endpackage
